// File: source/intersect_macros.svh
//==========================================================
// Intersection stage parameters
// Fixed-point format, math latency and output queue sizing
//==========================================================
`ifndef INTERSECT_MACROS_SVH
`define INTERSECT_MACROS_SVH

// Fraction bits of a Q8.8 coordinate
`define FRAC_BITS 8

// Math pipeline latency, also the side-data delay
`define INT_MATH_LAT 5

// Output queues
`define FIFO_DEPTH 16
`define FIFO_AW 4     // log2 of FIFO_DEPTH

// 1.0 in the Q16.16 product format
`define ONE_Q 65536

`endif

// File: source/intersect_pkg.sv
//==========================================================
// Intersection stage types
// Plain vector types for coordinates, products, side data
// and queue occupancy
//==========================================================
`default_nettype none

package intersect_pkg;

  //==========================================================
  // Geometry
  //==========================================================
  typedef logic signed [15:0] coord_t;  // Q8.8 coordinate or matrix entry
  typedef logic signed [31:0] prod_t;   // Q16.16
  typedef logic signed [63:0] wide_t;   // Q32.32 barycentric numerators

  //==========================================================
  // Request side data
  //==========================================================
  typedef logic [7:0]  ray_info_t;  // Ray tag
  typedef logic [15:0] tri_id_t;
  typedef logic [14:0] lindex_t;    // Position in the leaf list
  typedef logic [4:0]  lnum_t;      // Triangles left in the leaf

  // Queue occupancy, 0 to 16
  typedef logic [4:0] used_t;

endpackage

`default_nettype wire

// File: source/int_math.sv
//==========================================================
// Ray-triangle intersection math
// Five-stage fixed-point pipeline, never stalls. Moves the ray
// into unit-triangle space and runs a divider-free
// barycentric hit test
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "intersect_macros.svh"

module int_math import intersect_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic [143:0] tri_m,    // Row-major, m[r][c] at bit (3r+c)*16
  input  logic [47:0]  tri_t,    // x in [15:0], y in [31:16], z in [47:32]
  input  logic [47:0]  ray_org,
  input  logic [47:0]  ray_dir,
  output logic         hit,
  output prod_t        t_num,
  output prod_t        t_den      // Always positive on a hit
);

  coord_t m1 [3][3];  // Stage 1 input copies
  coord_t t1 [3];
  coord_t o1 [3];
  coord_t d1 [3];
  prod_t  po2 [3][3]; // Stage 2 products
  prod_t  pd2 [3][3];
  prod_t  t2 [3];
  prod_t  o3 [3];     // Stage 3 transformed origin and direction
  prod_t  d3 [3];
  prod_t  den_c;
  prod_t  tnum_c;
  prod_t  den4;       // Stage 4 numerators
  prod_t  tnum4;
  wide_t  u4;
  wide_t  v4;
  wide_t  uv_sum;
  wide_t  den_one;

  //==========================================================
  // Stages 1 to 3: o' = M*o + T, d' = M*d
  //==========================================================
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        m1[r][c] <= tri_m[(3*r+c)*16 +: 16];
      end
      t1[r] <= tri_t[r*16 +: 16];
      o1[r] <= ray_org[r*16 +: 16];
      d1[r] <= ray_dir[r*16 +: 16];
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        po2[r][c] <= prod_t'(m1[r][c]) * prod_t'(o1[c]);  // Q8.8 x Q8.8
        pd2[r][c] <= prod_t'(m1[r][c]) * prod_t'(d1[c]);
      end
      t2[r] <= prod_t'(t1[r]) <<< `FRAC_BITS;  // Align translation to Q16.16
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      o3[r] <= po2[r][0] + po2[r][1] + po2[r][2] + t2[r];
      d3[r] <= pd2[r][0] + pd2[r][1] + pd2[r][2];
    end
  end

  //==========================================================
  // Stage 4: t = tnum/den against the z = 0 plane
  //==========================================================
  // Keep den positive so the later compares need no sign flip
  always_comb begin
    den_c  = d3[2];
    tnum_c = -o3[2];
    if (d3[2] < 0) begin
      den_c  = -d3[2];
      tnum_c = o3[2];
    end
  end

  // u*den and v*den, both Q32.32
  always_ff @(posedge clk) begin
    den4  <= den_c;
    tnum4 <= tnum_c;
    u4    <= wide_t'(o3[0]) * wide_t'(den_c) + wide_t'(tnum_c) * wide_t'(d3[0]);
    v4    <= wide_t'(o3[1]) * wide_t'(den_c) + wide_t'(tnum_c) * wide_t'(d3[1]);
  end

  //==========================================================
  // Stage 5: hit decision
  //==========================================================
  assign uv_sum  = u4 + v4;
  assign den_one = wide_t'(den4) * `ONE_Q;  // den in Q32.32 scale

  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= (den4 != 0) && (tnum4 > 0) && (u4 >= 0) && (v4 >= 0) && (uv_sum <= den_one);
    end
  end

  always_ff @(posedge clk) begin
    t_num <= tnum4;
    t_den <= den4;
  end

endmodule

`default_nettype wire

// File: source/pipe_valid_stall.sv
//==========================================================
// Side-data delay line
// Carries request data beside the math pipeline, counts the
// items in flight and stalls upstream when credits run out
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module pipe_valid_stall import intersect_pkg::*; #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 5    // Equal to the math latency and at least 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             us_valid,
  input  logic [WIDTH-1:0] us_data,
  input  used_t            num_left,   // Free slots in the fuller queue
  output logic             us_stall,
  output logic             ds_valid,
  output logic [WIDTH-1:0] ds_data
);

  logic [WIDTH-1:0] data_sr [DEPTH];
  logic [DEPTH-1:0] valid_sr;
  used_t            in_flight;
  logic             accept;

  // Each item in flight may take one slot in each queue
  assign us_stall = us_valid && (in_flight >= num_left);
  assign accept   = us_valid && !us_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[DEPTH-2:0], accept};
    end
  end

  always_ff @(posedge clk) begin
    data_sr[0] <= us_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({accept, ds_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;  // Leaves as its queue write lands
        default: in_flight <= in_flight;
      endcase
    end
  end

  assign ds_valid = valid_sr[DEPTH-1];
  assign ds_data  = data_sr[DEPTH-1];

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
//==========================================================
// Synchronous FIFO
// Show-ahead read, occupancy count, full and empty flags
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module sync_fifo import intersect_pkg::*; #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,  // 2**AW
  parameter int AW    = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             full,
  output used_t            used
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign empty   = (used == '0);
  assign full    = (used == used_t'(DEPTH));
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign rd_data = mem[rd_ptr];  // Head is visible before the read

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap naturally
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/int_unit.sv
//==========================================================
// Ray-triangle intersection unit
// Runs the hit test, advances the leaf-list position and
// sorts results into the list and leaf-arbiter queues.
// Input is credit throttled so the math never stops
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "intersect_macros.svh"

module int_unit import intersect_pkg::*; (
  input  logic         clk,
  input  logic         rst,

  // Request from the reservation station
  input  logic         rs_to_int_valid,
  input  logic [143:0] tri_m,
  input  logic [47:0]  tri_t,
  input  logic [47:0]  ray_org,
  input  logic [47:0]  ray_dir,
  input  ray_info_t    ray_info,
  input  tri_id_t      tri_id,
  input  lindex_t      lindex,
  input  lnum_t        lnum_left,
  output logic         rs_to_int_stall,

  // Hits and leaf ends to the list unit
  output logic         int_to_list_valid,
  output ray_info_t    int_to_list_ray_info,
  output tri_id_t      int_to_list_tri_id,
  output logic         int_to_list_hit,
  output logic         int_to_list_is_last,
  output prod_t        int_to_list_t_num,
  output prod_t        int_to_list_t_den,
  input  logic         int_to_list_stall,

  // Next list position to the leaf arbiter
  output logic         int_to_larb_valid,
  output ray_info_t    int_to_larb_ray_info,
  output lindex_t      int_to_larb_lindex,
  output lnum_t        int_to_larb_lnum_left,
  input  logic         int_to_larb_stall
);

  localparam int SIDE_W = $bits(ray_info_t) + $bits(tri_id_t) + $bits(lindex_t) + $bits(lnum_t);
  localparam int LIST_W = $bits(ray_info_t) + $bits(tri_id_t) + 2 + 2 * $bits(prod_t);  // 90
  localparam int LARB_W = $bits(ray_info_t) + $bits(lindex_t) + $bits(lnum_t);          // 28

  logic              hit;
  prod_t             t_num;
  prod_t             t_den;
  logic [SIDE_W-1:0] side_in;
  logic [SIDE_W-1:0] side_out;
  logic              exit_valid;
  ray_info_t         exit_ray_info;
  tri_id_t           exit_tri_id;
  lindex_t           exit_lindex;
  lnum_t             exit_lnum_left;
  logic              is_last;
  logic              list_wr, list_rd, list_empty, list_full;
  logic              larb_wr, larb_rd, larb_empty, larb_full;
  logic [LIST_W-1:0] list_din, list_dout;
  logic [LARB_W-1:0] larb_din, larb_dout;
  used_t             list_used, larb_used, max_used, num_left;

  //==========================================================
  // Math and side-data pipelines, equal latency
  //==========================================================
  int_math math_inst (
    .clk, .rst, .tri_m, .tri_t, .ray_org, .ray_dir, .hit, .t_num, .t_den
  );

  // List position is advanced on the way in
  assign side_in = {ray_info, tri_id, lindex + 1'b1, lnum_left - 1'b1};

  pipe_valid_stall #(.WIDTH(SIDE_W), .DEPTH(`INT_MATH_LAT)) pipe_inst (
    .clk, .rst,
    .us_valid (rs_to_int_valid),
    .us_data  (side_in),
    .num_left (num_left),
    .us_stall (rs_to_int_stall),
    .ds_valid (exit_valid),
    .ds_data  (side_out)
  );

  assign {exit_ray_info, exit_tri_id, exit_lindex, exit_lnum_left} = side_out;

  //==========================================================
  // Routing into the output queues
  //==========================================================
  assign is_last = (exit_lnum_left == '0);   // Nothing left after this one
  assign list_wr = exit_valid && (hit || is_last);
  assign larb_wr = exit_valid && !is_last;
  assign list_din = {exit_ray_info, exit_tri_id, hit, is_last, t_num, t_den};
  assign larb_din = {exit_ray_info, exit_lindex, exit_lnum_left};

  sync_fifo #(.WIDTH(LIST_W), .DEPTH(`FIFO_DEPTH), .AW(`FIFO_AW)) list_fifo (
    .clk, .rst, .wr_en(list_wr), .wr_data(list_din), .rd_en(list_rd),
    .rd_data(list_dout), .empty(list_empty), .full(list_full), .used(list_used)
  );

  sync_fifo #(.WIDTH(LARB_W), .DEPTH(`FIFO_DEPTH), .AW(`FIFO_AW)) larb_fifo (
    .clk, .rst, .wr_en(larb_wr), .wr_data(larb_din), .rd_en(larb_rd),
    .rd_data(larb_dout), .empty(larb_empty), .full(larb_full), .used(larb_used)
  );

  assign {int_to_list_ray_info, int_to_list_tri_id, int_to_list_hit,
          int_to_list_is_last, int_to_list_t_num, int_to_list_t_den} = list_dout;
  assign int_to_list_valid = !list_empty;
  assign list_rd           = int_to_list_valid && !int_to_list_stall;

  assign {int_to_larb_ray_info, int_to_larb_lindex, int_to_larb_lnum_left} = larb_dout;
  assign int_to_larb_valid = !larb_empty;
  assign larb_rd           = int_to_larb_valid && !int_to_larb_stall;

  // Credits from the fuller queue
  assign max_used = (list_used > larb_used) ? list_used : larb_used;
  assign num_left = used_t'(`FIFO_DEPTH) - max_used;

endmodule

`default_nettype wire

// File: tests/int_unit_assert.sv
//==========================================================
// Intersection unit checks
// Queue overflow, output hold under stall, reset state
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module int_unit_assert (
  input logic        clk,
  input logic        rst,
  input logic        list_wr,
  input logic        list_full,
  input logic        larb_wr,
  input logic        larb_full,
  input logic        list_valid,
  input logic        list_stall,
  input logic [89:0] list_data,
  input logic        larb_valid,
  input logic        larb_stall,
  input logic [27:0] larb_data,
  input logic        in_stall
);

  // Credits must keep every write away from a full queue
  list_no_overflow: assert property (@(posedge clk) disable iff (rst) list_wr |-> !list_full)
    else $error("List FIFO written while full");
  larb_no_overflow: assert property (@(posedge clk) disable iff (rst) larb_wr |-> !larb_full)
    else $error("Leaf arbiter FIFO written while full");

  //==========================================================
  // Output hold while stalled
  //==========================================================
  list_hold: assert property (@(posedge clk) disable iff (rst)
    list_valid && list_stall |=> list_valid && $stable(list_data))
    else $error("List output changed while stalled");
  larb_hold: assert property (@(posedge clk) disable iff (rst)
    larb_valid && larb_stall |=> larb_valid && $stable(larb_data))
    else $error("Leaf arbiter output changed while stalled");

  reset_quiet: assert property (@(posedge clk) rst |=> !list_valid && !larb_valid && !in_stall)
    else $error("Outputs active right after reset");

endmodule

bind int_unit int_unit_assert assert_inst (
  .clk, .rst, .list_wr, .list_full, .larb_wr, .larb_full,
  .list_valid (int_to_list_valid),
  .list_stall (int_to_list_stall),
  .list_data  (list_dout),
  .larb_valid (int_to_larb_valid),
  .larb_stall (int_to_larb_stall),
  .larb_data  (larb_dout),
  .in_stall   (rs_to_int_stall)
);

`default_nettype wire

// File: tests/int_unit_tb.sv
//==========================================================
// Intersection unit testbench
// Constructed and random rays, reference model, list and
// leaf-arbiter scoreboards, closing report
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "intersect_macros.svh"

module int_unit_tb import intersect_pkg::*; ();

  localparam int TIMEOUT = 400;

  logic         clk;
  logic         rst;
  logic         rs_to_int_valid;
  logic [143:0] tri_m;
  logic [47:0]  tri_t;
  logic [47:0]  ray_org;
  logic [47:0]  ray_dir;
  ray_info_t    ray_info;
  tri_id_t      tri_id;
  lindex_t      lindex;
  lnum_t        lnum_left;
  logic         rs_to_int_stall;
  logic         int_to_list_valid;
  ray_info_t    int_to_list_ray_info;
  tri_id_t      int_to_list_tri_id;
  logic         int_to_list_hit;
  logic         int_to_list_is_last;
  prod_t        int_to_list_t_num;
  prod_t        int_to_list_t_den;
  logic         int_to_list_stall;
  logic         int_to_larb_valid;
  ray_info_t    int_to_larb_ray_info;
  lindex_t      int_to_larb_lindex;
  lnum_t        int_to_larb_lnum_left;
  logic         int_to_larb_stall;

  int          tm [9];   // Raw Q8.8 request values
  int          tt [3];
  int          ro [3];
  int          rd [3];
  logic [89:0] exp_list [$];
  logic [27:0] exp_larb [$];
  logic [31:0] rng;
  logic [31:0] stall_rng;
  logic        stall_on;
  logic        saw_stall;
  logic [15:0] tag;
  int          errors;
  int          n_list;
  int          n_larb;

  int_unit int_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int next_rand(input int span);
    rng = xorshift(rng);
    return int'(rng % span);
  endfunction

  //==========================================================
  // Reference model
  //==========================================================
  task automatic compute_expected(output logic hit, output longint tn, output longint den);
    longint orig [3];
    longint dirv [3];
    longint u;
    longint v;
    for (int r = 0; r < 3; r++) begin
      orig[r] = longint'(tt[r]) * (1 << `FRAC_BITS);  // Translation into Q16.16
      dirv[r] = 0;
      for (int c = 0; c < 3; c++) begin
        orig[r] += longint'(tm[3*r+c]) * ro[c];
        dirv[r] += longint'(tm[3*r+c]) * rd[c];
      end
    end
    den = dirv[2];
    tn  = -orig[2];
    if (den < 0) begin
      den = -den;
      tn  = -tn;
    end
    u = orig[0] * den + tn * dirv[0];
    v = orig[1] * den + tn * dirv[1];
    hit = (den != 0) && (tn > 0) && (u >= 0) && (v >= 0) && (u + v <= den * `ONE_Q);
  endtask

  task automatic push_expected();
    logic   hit;
    logic   last;
    longint tn;
    longint den;
    compute_expected(hit, tn, den);
    last = (lnum_left == 5'd1);  // One left means this is the leaf's final triangle
    if (hit || last) begin
      exp_list.push_back({ray_info, tri_id, hit, last, tn[31:0], den[31:0]});
    end
    if (!last) begin
      exp_larb.push_back({ray_info, lindex_t'(lindex + 15'd1), lnum_t'(lnum_left - 5'd1)});
    end
  endtask

  // Accepted requests feed the scoreboards
  always @(posedge clk) begin
    if (!rst && rs_to_int_valid) begin
      if (rs_to_int_stall) saw_stall = 1'b1;
      else push_expected();
    end
  end

  //==========================================================
  // Output checkers
  //==========================================================
  always @(posedge clk) begin
    logic [89:0] got;
    if (!rst && int_to_list_valid && !int_to_list_stall) begin
      got = {int_to_list_ray_info, int_to_list_tri_id, int_to_list_hit,
             int_to_list_is_last, int_to_list_t_num, int_to_list_t_den};
      if (exp_list.size() == 0) begin
        $display("Unexpected list record %h at %0t ns", got, $time);
        errors++;
      end else begin
        n_list++;
        list_ok: assert (got == exp_list[0]) else begin
          $display("[FAIL] %0t ns list record %h, expected %h", $time, got, exp_list[0]);
          errors++;
        end
        void'(exp_list.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    logic [27:0] got;
    if (!rst && int_to_larb_valid && !int_to_larb_stall) begin
      got = {int_to_larb_ray_info, int_to_larb_lindex, int_to_larb_lnum_left};
      if (exp_larb.size() == 0) begin
        $display("Unexpected leaf arbiter record %h at %0t ns", got, $time);
        errors++;
      end else begin
        n_larb++;
        larb_ok: assert (got == exp_larb[0]) else begin
          $display("[FAIL] %0t ns larb record %h, expected %h", $time, got, exp_larb[0]);
          errors++;
        end
        void'(exp_larb.pop_front());
      end
    end
  end

  // Downstream back-pressure about 7 cycles in 8
  initial begin
    int_to_list_stall = 1'b0;
    int_to_larb_stall = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      stall_rng = xorshift(stall_rng);
      int_to_list_stall = stall_on && (stall_rng[2:0] != 3'd0);
      int_to_larb_stall = stall_on && (stall_rng[5:3] != 3'd0);
    end
  end

  //==========================================================
  // Stimulus tasks
  //==========================================================
  // Each task starts and ends 2 ns after a clock edge
  task automatic set_identity(input int ox, input int oy, input int oz, input int dz);
    for (int k = 0; k < 9; k++) tm[k] = (k % 4 == 0) ? 256 : 0;  // 1.0 on the diagonal
    tt = '{0, 0, 0};
    ro = '{ox, oy, oz};
    rd = '{0, 0, dz};
  endtask

  task automatic send_request(input int lnum);
    int waited;
    tag = tag + 16'd1;
    rs_to_int_valid = 1'b1;
    for (int k = 0; k < 9; k++) tri_m[k*16 +: 16] = tm[k][15:0];
    for (int k = 0; k < 3; k++) begin
      tri_t[k*16 +: 16]   = tt[k][15:0];
      ray_org[k*16 +: 16] = ro[k][15:0];
      ray_dir[k*16 +: 16] = rd[k][15:0];
    end
    ray_info  = tag[7:0];
    tri_id    = tag;
    lindex    = lindex_t'(next_rand(32768));
    lnum_left = lnum_t'(lnum);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (rs_to_int_stall && waited < TIMEOUT);
    if (rs_to_int_stall) begin
      $display("Request %0d was never accepted", tag);
      errors++;
    end
    #2;
    rs_to_int_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_list.size() != 0 || exp_larb.size() != 0) && waited < 4 * TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_list.size() != 0 || exp_larb.size() != 0) begin
      $display("Expected records never arrived: %0d list, %0d larb",
               exp_list.size(), exp_larb.size());
      errors++;
    end
    repeat (8) @(posedge clk);  // Room for stray records to show
    #2;
  endtask

  task automatic check_latency();
    int n;
    set_identity(32, 32, 256, -256);
    send_request(2);
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!int_to_list_valid && n < TIMEOUT);
    latency_ok: assert (n == `INT_MATH_LAT + 1 && int_to_larb_valid) else begin
      $display("[FAIL] %0t ns first output after %0d cycles, expected %0d",
               $time, n, `INT_MATH_LAT + 1);
      errors++;
    end
    #2;
  endtask

  //==========================================================
  // Main sequence
  //==========================================================
  initial begin
    rst = 1'b1;
    rs_to_int_valid = 1'b0;
    tri_m = '0;
    tri_t = '0;
    ray_org = '0;
    ray_dir = '0;
    ray_info = '0;
    tri_id = '0;
    lindex = '0;
    lnum_left = '0;
    rng = 32'h4855;
    stall_rng = xorshift(32'h4855);
    stall_on = 1'b0;
    saw_stall = 1'b0;
    tag = '0;
    errors = 0;
    n_list = 0;
    n_larb = 0;
    repeat (16) @(posedge clk);
    #2 rst = 1'b0;
    @(posedge clk);
    reset_ok: assert (!int_to_list_valid && !int_to_larb_valid && !rs_to_int_stall) else begin
      $display("[FAIL] %0t ns outputs active after reset", $time);
      errors++;
    end
    #2;
    check_latency();
    wait_drain();

    // Straight down onto the triangle
    for (int i = 0; i < 8; i++) begin
      set_identity(next_rand(100), next_rand(100), 256 + next_rand(256), -(128 + next_rand(128)));
      send_request(i % 3 + 1);
    end
    for (int i = 0; i < 6; i++) begin
      case (i % 3)
        0: set_identity(150 + next_rand(100), 150, 256, -256);  // Outside the edges
        1: begin
          set_identity(40, 40, 256, 0);
          rd[0] = 256;  // Parallel to the plane
        end
        default: set_identity(40, 40, 256, 256);  // Triangle behind the origin
      endcase
      send_request(i % 2 + 1);
    end
    wait_drain();

    stall_on = 1'b1;
    for (int i = 0; i < 60; i++) begin
      for (int k = 0; k < 9; k++) tm[k] = next_rand(1024) - 512;
      for (int k = 0; k < 3; k++) begin
        tt[k] = next_rand(2048) - 1024;
        ro[k] = next_rand(2048) - 1024;
        rd[k] = next_rand(2048) - 1024;
      end
      send_request(next_rand(4) + 1);
    end
    stall_on = 1'b0;
    wait_drain();
    stall_seen: assert (saw_stall) else begin
      $display("Request stall never rose under back-pressure");
      errors++;
    end

    $display("Checked %0d list and %0d larb records, %0d errors", n_list, n_larb, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: int_unit.f
+incdir+source
source/intersect_pkg.sv
source/int_math.sv
source/pipe_valid_stall.sv
source/sync_fifo.sv
source/int_unit.sv
tests/int_unit_assert.sv
tests/int_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the intersection unit testbench with Verilator, run it,
# and look for the pass line in the simulation log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module int_unit_tb -f int_unit.f \
  -o int_unit_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

(./obj_dir/int_unit_sim > sim.log 2>&1 || true) &&
  grep -qx "Testbench passed" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }
